/* flist.f */
hw/shader_pkg.sv
hw/triangle_normal.sv
hw/normal_magnitude.sv
hw/angle_index.sv
hw/color_map.sv
hw/pixel_shader.sv
sim/pixel_shader_props.sv
sim/shader_checker.sv
sim/pixel_shader_tb.sv

/* Bender.yml */
package:
  name: pixel_shader

sources:
  - hw/shader_pkg.sv
  - hw/triangle_normal.sv
  - hw/normal_magnitude.sv
  - hw/angle_index.sv
  - hw/color_map.sv
  - hw/pixel_shader.sv
  - target: simulation
    files:
      - sim/pixel_shader_props.sv
      - sim/shader_checker.sv
      - sim/pixel_shader_tb.sv

/* sim/pixel_shader_tb.sv */
module pixel_shader_tb;

    import shader_pkg::*;

    localparam int coord_w = 10;
    localparam int reset_cycles = 5;
    localparam int idle_cycles = 3;
    localparam int hand_rows = 9;
    localparam int n_rows = hand_rows + 12;
    localparam int timeout_cycles = reset_cycles + idle_cycles + n_rows + pipe_latency + 20;

    logic                      clk = 1'b0;
    logic                      rst_in = 1'b1;
    logic                      data_valid_in = 1'b0;
    logic signed [coord_w-1:0] v0_x = '0, v0_y = '0, v0_z = '0;
    logic signed [coord_w-1:0] v1_x = '0, v1_y = '0, v1_z = '0;
    logic signed [coord_w-1:0] v2_x = '0, v2_y = '0, v2_z = '0;
    logic                      valid_out;
    logic [color_w-1:0]        color_out;

    // stimulus table with columns v0 xyz, v1 xyz, v2 xyz
    string  names [0:n_rows-1];
    int     coords [0:n_rows-1][0:8];
    int     expected [0:n_rows-1];
    int     grey_levels [0:15] = '{0, 20, 40, 60, 78, 96, 114, 130,
                                   146, 162, 178, 194, 210, 226, 242, 255};
    integer seed = 32'h7d1f;
    int     cycle_count = 0;

    pixel_shader #(.coord_w(coord_w)) pixel_shader_inst (
        .clk(clk), .rst_in(rst_in), .data_valid_in(data_valid_in),
        .v0_x(v0_x), .v0_y(v0_y), .v0_z(v0_z),
        .v1_x(v1_x), .v1_y(v1_y), .v1_z(v1_z),
        .v2_x(v2_x), .v2_y(v2_y), .v2_z(v2_z),
        .valid_out(valid_out), .color_out(color_out)
    );

    shader_checker shader_checker_inst (
        .clk(clk), .rst_in(rst_in), .data_valid_in(data_valid_in),
        .valid_out(valid_out), .color_out(color_out)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // back faces are white and front faces follow floor(16 nz^2 / |n|^2)
    function automatic int expected_color(input int r);
        longint ux, uy, uz, wx, wy, wz;
        longint nx, ny, nz, mag, idx;
        ux = coords[r][3] - coords[r][0];
        uy = coords[r][4] - coords[r][1];
        uz = coords[r][5] - coords[r][2];
        wx = coords[r][6] - coords[r][0];
        wy = coords[r][7] - coords[r][1];
        wz = coords[r][8] - coords[r][2];
        nx = uy * wz - uz * wy;
        ny = uz * wx - ux * wz;
        nz = ux * wy - uy * wx;
        mag = nx * nx + ny * ny + nz * nz;
        if (nz < 0) begin
            return 255;
        end
        idx = (mag == 0) ? 0 : (16 * nz * nz) / mag;
        if (idx > 15) begin
            idx = 15;
        end
        return grey_levels[idx];
    endfunction

    task automatic add_row(input int r, input string name,
                           input int x0, input int y0, input int z0,
                           input int x1, input int y1, input int z1,
                           input int x2, input int y2, input int z2, input int color);
        names[r] = name;
        coords[r] = '{x0, y0, z0, x1, y1, z1, x2, y2, z2};
        expected[r] = color;
    endtask

    task automatic fill_table();
        add_row(0, "flat_xy", 0, 0, 0, 4, 0, 0, 0, 4, 0, 255);
        add_row(1, "tilt_45", 0, 0, 0, 4, 0, 4, 0, 4, 0, 146);
        add_row(2, "back_face", 0, 0, 0, 0, 4, 0, 4, 0, 0, 255);
        // reversed tilt_45 would shade as 146 without the back-face rule
        add_row(3, "back_tilt", 0, 0, 0, 0, 4, 0, 4, 0, 4, 255);
        add_row(4, "edge_on", 0, 0, 0, 4, 0, 0, 0, 0, 4, 0);
        add_row(5, "collinear", 1, 2, 3, 2, 4, 6, 3, 6, 9, 0);
        // normal along (1,1,1) gives cos^2 of one third
        add_row(6, "diagonal", 4, 0, 0, 0, 4, 0, 0, 0, 4, 96);
        add_row(7, "offset_flat", -100, -50, 7, -96, -50, 7, -100, -46, 7, 255);
        add_row(8, "flat_large", -512, -512, 0, 511, -512, 0, -512, 511, 0, 255);
        for (int r = hand_rows; r < n_rows; r++) begin
            names[r] = $sformatf("random_%0d", r - hand_rows);
            for (int i = 0; i < 9; i++) begin
                coords[r][i] = $random(seed) % 512;
            end
            expected[r] = expected_color(r);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles with colors still missing", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        fill_table();
        repeat (reset_cycles) @(posedge clk);
        rst_in <= 1'b0;
        repeat (idle_cycles) @(posedge clk);
        @(negedge clk);
        shader_checker_inst.check_after_reset();

        // back-to-back triangles at one per cycle
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            data_valid_in <= 1'b1;
            v0_x <= coords[r][0][coord_w-1:0];
            v0_y <= coords[r][1][coord_w-1:0];
            v0_z <= coords[r][2][coord_w-1:0];
            v1_x <= coords[r][3][coord_w-1:0];
            v1_y <= coords[r][4][coord_w-1:0];
            v1_z <= coords[r][5][coord_w-1:0];
            v2_x <= coords[r][6][coord_w-1:0];
            v2_y <= coords[r][7][coord_w-1:0];
            v2_z <= coords[r][8][coord_w-1:0];
            shader_checker_inst.push_expected(names[r], expected[r][color_w-1:0]);
        end
        @(posedge clk);
        data_valid_in <= 1'b0;

        while (shader_checker_inst.results_seen < n_rows) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        shader_checker_inst.report_counts();
        if (shader_checker_inst.error_count == 0 &&
            pixel_shader_inst.pixel_shader_props_inst.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim/shader_checker.sv */
module shader_checker (
    input logic                         clk,
    input logic                         rst_in,
    input logic                         data_valid_in,
    input logic                         valid_out,
    input logic [shader_pkg::color_w-1:0] color_out
);

    import shader_pkg::*;

    string              name_q[$];
    logic [color_w-1:0] color_q[$];
    // cycle at which each triangle entered the DUT
    int                 start_q[$];
    int                 cycle = 0;
    int                 results_seen = 0;
    int                 test_count = 0;
    int                 pass_count = 0;
    int                 error_count = 0;

    task automatic push_expected(input string name, input logic [color_w-1:0] color);
        name_q.push_back(name);
        color_q.push_back(color);
    endtask

    task automatic check_after_reset();
        test_count++;
        if (valid_out !== 1'b0 || color_out !== '0) begin
            $display("FAIL after_reset expected %0d actual %0d (valid_out %b)",
                     0, color_out, valid_out);
            error_count++;
        end else begin
            $display("PASS after_reset");
            pass_count++;
        end
    endtask

    always @(posedge clk) begin
        string              name;
        logic [color_w-1:0] want;
        int                 start;
        if (!rst_in && data_valid_in) begin
            start_q.push_back(cycle);
        end
        if (!rst_in && valid_out) begin
            if (color_q.size() == 0 || start_q.size() == 0) begin
                $display("valid_out pulsed with no triangle in flight");
                error_count++;
            end else begin
                name = name_q.pop_front();
                want = color_q.pop_front();
                start = start_q.pop_front();
                results_seen++;
                test_count++;
                if (color_out !== want) begin
                    $display("FAIL %s expected %0d actual %0d", name, want, color_out);
                    error_count++;
                end else if (cycle - start != pipe_latency) begin
                    $display("%s: color came %0d cycles after its input instead of %0d",
                             name, cycle - start, pipe_latency);
                    error_count++;
                end else begin
                    $display("PASS %s color %0d", name, color_out);
                    pass_count++;
                end
            end
        end
        cycle++;
    end

    task automatic report_counts();
        if (name_q.size() != 0) begin
            $display("%0d expected colors never came out of the DUT", name_q.size());
            error_count += name_q.size();
        end
        $display("tests %0d, passed %0d, errors %0d", test_count, pass_count, error_count);
    endtask

endmodule

/* sim/pixel_shader_props.sv */
module pixel_shader_props (
    input logic clk,
    input logic rst_in,
    input logic data_valid_in,
    input logic valid_out
);

    import shader_pkg::*;

    int fail_count = 0;

    // a reset edge leaves the output strobe low on the following edge
    reset_quiet: assert property (@(posedge clk) rst_in |=> !valid_out)
        else begin
            $error("valid_out high after a reset cycle");
            fail_count++;
        end

    // the strobe stays low on the edge after reset ends
    reset_release: assert property (@(posedge clk) $fell(rst_in) |=> !valid_out)
        else begin
            $error("valid_out high in the cycle after reset ends");
            fail_count++;
        end

    strobe_latency: assert property (@(posedge clk) disable iff (rst_in)
        data_valid_in |-> ##pipe_latency valid_out)
        else begin
            $error("valid_out missing %0d cycles after data_valid_in", pipe_latency);
            fail_count++;
        end

    // every output strobe traces back to an input strobe
    no_stray_strobe: assert property (@(posedge clk) disable iff (rst_in)
        valid_out |-> $past(data_valid_in, pipe_latency))
        else begin
            $error("valid_out without a matching data_valid_in");
            fail_count++;
        end

endmodule

bind pixel_shader pixel_shader_props pixel_shader_props_inst (
    .clk(clk), .rst_in(rst_in), .data_valid_in(data_valid_in), .valid_out(valid_out)
);

/* hw/pixel_shader.sv */
module pixel_shader #(
    parameter int coord_w = 10
) (
    input  logic                         clk,
    input  logic                         rst_in,
    input  logic                         data_valid_in,
    input  logic signed [coord_w-1:0]     v0_x,
    input  logic signed [coord_w-1:0]     v0_y,
    input  logic signed [coord_w-1:0]     v0_z,
    input  logic signed [coord_w-1:0]     v1_x,
    input  logic signed [coord_w-1:0]     v1_y,
    input  logic signed [coord_w-1:0]     v1_z,
    input  logic signed [coord_w-1:0]     v2_x,
    input  logic signed [coord_w-1:0]     v2_y,
    input  logic signed [coord_w-1:0]     v2_z,
    output logic                         valid_out,
    output logic [shader_pkg::color_w-1:0] color_out
);

    import shader_pkg::*;

    localparam int norm_w = 2 * (coord_w + 1) + 1;
    localparam int sq_w = 2 * norm_w;
    localparam int mag_w = sq_w + 2;

    // cross product stage to magnitude stage
    logic                     normal_valid;
    logic signed [norm_w-1:0] normal_x, normal_y, normal_z;

    // magnitude stage to index stage
    logic                     square_valid;
    logic [sq_w-1:0]          z_square;
    logic [mag_w-1:0]         magnitude;
    logic                     facing_away;

    // index stage to color lookup
    logic                     index_valid;
    logic [index_w-1:0]       index;
    logic                     index_facing_away;

    triangle_normal #(.coord_w(coord_w)) triangle_normal_inst (
        .clk(clk), .rst_in(rst_in), .data_valid_in(data_valid_in),
        .v0_x(v0_x), .v0_y(v0_y), .v0_z(v0_z),
        .v1_x(v1_x), .v1_y(v1_y), .v1_z(v1_z),
        .v2_x(v2_x), .v2_y(v2_y), .v2_z(v2_z),
        .normal_valid(normal_valid),
        .normal_x(normal_x), .normal_y(normal_y), .normal_z(normal_z)
    );

    normal_magnitude #(.coord_w(coord_w)) normal_magnitude_inst (
        .clk(clk), .rst_in(rst_in), .normal_valid(normal_valid),
        .normal_x(normal_x), .normal_y(normal_y), .normal_z(normal_z),
        .square_valid(square_valid), .z_square(z_square),
        .magnitude(magnitude), .facing_away(facing_away)
    );

    angle_index #(.coord_w(coord_w)) angle_index_inst (
        .clk(clk), .rst_in(rst_in), .square_valid(square_valid),
        .z_square(z_square), .magnitude(magnitude), .facing_away(facing_away),
        .index_valid(index_valid), .index(index),
        .facing_away_out(index_facing_away)
    );

    color_map color_map_inst (
        .clk(clk), .rst_in(rst_in), .index_valid(index_valid),
        .index(index), .facing_away(index_facing_away),
        .valid_out(valid_out), .color_out(color_out)
    );

endmodule

/* hw/color_map.sv */
module color_map (
    input  logic                         clk,
    input  logic                         rst_in,
    input  logic                         index_valid,
    input  logic [shader_pkg::index_w-1:0] index,
    input  logic                         facing_away,
    output logic                         valid_out,
    output logic [shader_pkg::color_w-1:0] color_out
);

    import shader_pkg::*;

    logic [color_w-1:0] shade;

    // back faces get the fixed color instead of the table value
    always_comb begin
        if (facing_away) begin
            shade = color_backface;
        end else begin
            shade = color_table(index);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            color_out <= '0;
        end else begin
            valid_out <= index_valid;
            color_out <= shade;
        end
    end

endmodule

/* hw/angle_index.sv */
module angle_index #(
    parameter int coord_w = 10,
    localparam int norm_w = 2 * (coord_w + 1) + 1,
    localparam int sq_w = 2 * norm_w,
    localparam int mag_w = sq_w + 2
) (
    input  logic                         clk,
    input  logic                         rst_in,
    input  logic                         square_valid,
    input  logic [sq_w-1:0]               z_square,
    input  logic [mag_w-1:0]              magnitude,
    input  logic                         facing_away,
    output logic                         index_valid,
    output logic [shader_pkg::index_w-1:0] index,
    output logic                         facing_away_out
);

    import shader_pkg::*;

    // room for 16 * magnitude plus one spare bit
    localparam int cmp_w = mag_w + $clog2(index_scale) + 1;
    localparam int count_w = $clog2(index_scale + 1);

    logic [cmp_w-1:0]   scaled_z;
    logic [count_w-1:0] hit_count;
    logic [index_w-1:0] clamped;

    assign scaled_z = cmp_w'(z_square) * cmp_w'(index_scale);

    // count of k with k * |n|^2 <= 16 * nz^2 is floor(16 * cos^2)
    always_comb begin
        hit_count = '0;
        for (int k = 1; k <= index_scale; k++) begin
            if (cmp_w'(k) * cmp_w'(magnitude) <= scaled_z) begin
                hit_count = hit_count + 1'b1;
            end
        end
        // cos^2 of exactly 1 lands on 16
        if (hit_count >= count_w'(index_scale)) begin
            clamped = index_w'(index_scale - 1);
        end else begin
            clamped = index_w'(hit_count);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            index_valid <= 1'b0;
        end else begin
            index_valid <= square_valid;
        end
    end

    always_ff @(posedge clk) begin
        // degenerate triangle, every comparison would pass
        index <= (magnitude == '0) ? '0 : clamped;
        facing_away_out <= facing_away;
    end

endmodule

/* hw/normal_magnitude.sv */
module normal_magnitude #(
    parameter int coord_w = 10,
    localparam int norm_w = 2 * (coord_w + 1) + 1,
    localparam int sq_w = 2 * norm_w,
    localparam int mag_w = sq_w + 2
) (
    input  logic                    clk,
    input  logic                    rst_in,
    input  logic                    normal_valid,
    input  logic signed [norm_w-1:0] normal_x,
    input  logic signed [norm_w-1:0] normal_y,
    input  logic signed [norm_w-1:0] normal_z,
    output logic                    square_valid,
    output logic [sq_w-1:0]          z_square,
    output logic [mag_w-1:0]         magnitude,
    output logic                    facing_away
);

    logic [sq_w-1:0] x_sq, y_sq, z_sq;
    logic            sq_valid;
    // sign of nz, carried alongside the squares
    logic            z_negative;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            sq_valid <= 1'b0;
            square_valid <= 1'b0;
        end else begin
            sq_valid <= normal_valid;
            square_valid <= sq_valid;
        end
    end

    always_ff @(posedge clk) begin
        // squares are never negative, so they are kept unsigned
        x_sq <= normal_x * normal_x;
        y_sq <= normal_y * normal_y;
        z_sq <= normal_z * normal_z;
        z_negative <= normal_z[norm_w-1];

        // two guard bits cover the sum of three squares
        magnitude <= x_sq + y_sq + z_sq;
        z_square <= z_sq;
        facing_away <= z_negative;
    end

endmodule

/* hw/triangle_normal.sv */
module triangle_normal #(
    parameter int coord_w = 10,
    localparam int edge_w = coord_w + 1,
    localparam int prod_w = 2 * edge_w,
    localparam int norm_w = prod_w + 1
) (
    input  logic                     clk,
    input  logic                     rst_in,
    input  logic                     data_valid_in,
    input  logic signed [coord_w-1:0] v0_x,
    input  logic signed [coord_w-1:0] v0_y,
    input  logic signed [coord_w-1:0] v0_z,
    input  logic signed [coord_w-1:0] v1_x,
    input  logic signed [coord_w-1:0] v1_y,
    input  logic signed [coord_w-1:0] v1_z,
    input  logic signed [coord_w-1:0] v2_x,
    input  logic signed [coord_w-1:0] v2_y,
    input  logic signed [coord_w-1:0] v2_z,
    output logic                     normal_valid,
    output logic signed [norm_w-1:0]  normal_x,
    output logic signed [norm_w-1:0]  normal_y,
    output logic signed [norm_w-1:0]  normal_z
);

    // edge u = v1 - v0, edge w = v2 - v0
    logic signed [edge_w-1:0] u_x, u_y, u_z;
    logic signed [edge_w-1:0] w_x, w_y, w_z;
    logic                     edge_valid;

    // partial products of u x w
    logic signed [prod_w-1:0] p_yz, p_zy, p_zx, p_xz, p_xy, p_yx;
    logic                     prod_valid;

    // valid strobes follow the data one register at a time
    always_ff @(posedge clk) begin
        if (rst_in) begin
            edge_valid <= 1'b0;
            prod_valid <= 1'b0;
            normal_valid <= 1'b0;
        end else begin
            edge_valid <= data_valid_in;
            prod_valid <= edge_valid;
            normal_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1: edge vectors, sign extended by one bit
        u_x <= v1_x - v0_x;
        u_y <= v1_y - v0_y;
        u_z <= v1_z - v0_z;
        w_x <= v2_x - v0_x;
        w_y <= v2_y - v0_y;
        w_z <= v2_z - v0_z;

        // stage 2: six products
        p_yz <= u_y * w_z;
        p_zy <= u_z * w_y;
        p_zx <= u_z * w_x;
        p_xz <= u_x * w_z;
        p_xy <= u_x * w_y;
        p_yx <= u_y * w_x;

        // stage 3: cross product differences
        normal_x <= p_yz - p_zy;
        normal_y <= p_zx - p_xz;
        normal_z <= p_xy - p_yx;
    end

endmodule

/* hw/shader_pkg.sv */
package shader_pkg;

    // cos^2 table index, one entry per sixteenth of the unit range
    localparam int index_w = 4;
    localparam int index_scale = 16;

    // greyscale output
    localparam int color_w = 8;
    localparam logic [color_w-1:0] color_backface = 8'd255;

    // input strobe to output strobe, in clock cycles
    localparam int pipe_latency = 7;

    // brightness curve indexed by floor(16 * cos^2)
    function automatic logic [color_w-1:0] color_table(input logic [index_w-1:0] index);
        case (index)
            4'd0: color_table = 8'd0;
            4'd1: color_table = 8'd20;
            4'd2: color_table = 8'd40;
            4'd3: color_table = 8'd60;
            4'd4: color_table = 8'd78;
            4'd5: color_table = 8'd96;
            4'd6: color_table = 8'd114;
            4'd7: color_table = 8'd130;
            4'd8: color_table = 8'd146;
            4'd9: color_table = 8'd162;
            4'd10: color_table = 8'd178;
            4'd11: color_table = 8'd194;
            4'd12: color_table = 8'd210;
            4'd13: color_table = 8'd226;
            4'd14: color_table = 8'd242;
            // full brightness, saturated at the 8-bit limit
            default: color_table = 8'd255;
        endcase
    endfunction

endpackage
